// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  localparam addr_t reset_pc = 32'h8000_0000;

  // Cache geometry
  localparam int line_words  = 4;
  localparam int cache_lines = 16;

  localparam int index_w  = $clog2(cache_lines);
  localparam int offset_w = $clog2(line_words);      // Word offset inside a line
  localparam int tag_w    = $bits(addr_t) - index_w - offset_w;

  typedef logic [index_w-1:0]  index_t;
  typedef logic [offset_w-1:0] offset_t;
  typedef logic [tag_w-1:0]    tag_t;

  // Major opcode of BEQ/BNE/BLT/BGE/BLTU/BGEU
  localparam logic [4:0] branch_opcode = 5'b11000;

  // Fixed burst shape of a line refill
  localparam logic [7:0] axi_len_line   = 8'(line_words - 1);
  localparam logic [2:0] axi_size_word  = 3'd2;      // 4 bytes per beat
  localparam logic [1:0] axi_burst_incr = 2'b01;

  // Master to slave
  typedef struct packed {
    logic       arvalid;
    addr_t      araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic       rready;
  } axi_ar_t;

  // Slave to master
  typedef struct packed {
    logic       arready;
    logic       rvalid;
    inst_t      rdata;
    logic [1:0] rresp;
    logic       rlast;
  } axi_r_t;

endpackage

// ==== hw/icache.sv ====
`timescale 1ns/1ns

module icache (
  input  logic               clock,
  input  logic               reset,
  input  logic               fencei,
  input  fetch_pkg::addr_t   addr,
  output logic               hit,
  output fetch_pkg::inst_t   inst,
  output fetch_pkg::axi_ar_t mem_ar,
  input  fetch_pkg::axi_r_t  mem_r
);

  import fetch_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_fill
  } state_t;

  state_t state;

  inst_t data_q [cache_lines][line_words];
  tag_t  tag_q  [cache_lines];
  logic [cache_lines-1:0] valid_q;

  addr_t   refill_addr;                              // Line-aligned address of the refill
  index_t  refill_index;
  tag_t    refill_tag;
  offset_t beat_q;
  logic    refill_dropped;                           // fence.i seen while filling

  index_t  lookup_index;
  offset_t lookup_offset;
  tag_t    lookup_tag;
  addr_t   lookup_line;
  logic    beat;
  logic    last_beat;

  // Tag spans everything above the word offset, so it also repeats the upper index bits
  assign lookup_offset = addr[2 +: offset_w];
  assign lookup_index  = addr[2 + offset_w +: index_w];
  assign lookup_tag    = addr[$bits(addr_t)-1 -: tag_w];
  assign lookup_line   = {addr[$bits(addr_t)-1 : offset_w + 2], {(offset_w + 2){1'b0}}};

  assign refill_index = refill_addr[2 + offset_w +: index_w];
  assign refill_tag   = refill_addr[$bits(addr_t)-1 -: tag_w];

  assign hit  = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
  assign inst = data_q[lookup_index][lookup_offset];

  assign beat      = (state == st_fill) && mem_r.rvalid;
  assign last_beat = beat && mem_r.rlast;

  always_comb begin
    mem_ar.arvalid = (state == st_request);
    mem_ar.araddr  = refill_addr;
    mem_ar.arlen   = axi_len_line;
    mem_ar.arsize  = axi_size_word;
    mem_ar.arburst = axi_burst_incr;
    mem_ar.rready  = (state == st_fill);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state          <= st_idle;
      valid_q        <= '0;
      beat_q         <= '0;
      refill_dropped <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (!hit) begin
            state                 <= st_request;
            valid_q[lookup_index] <= 1'b0;   // Line is overwritten beat by beat
            refill_dropped        <= 1'b0;
          end
        end
        st_request: begin
          if (mem_r.arready) begin
            state  <= st_fill;
            beat_q <= '0;
          end
        end
        st_fill: begin
          if (beat) begin
            beat_q <= beat_q + 1'b1;
          end
          if (last_beat) begin
            state                 <= st_idle;
            valid_q[refill_index] <= !(refill_dropped || fencei);
          end
        end
        default: state <= st_idle;
      endcase

      if (fencei) begin
        valid_q <= '0;
        if (state != st_idle) begin
          refill_dropped <= 1'b1;
        end
      end
    end
  end

  // Arrays and refill address
  always_ff @(posedge clock) begin
    if (state == st_idle && !hit) begin
      refill_addr <= lookup_line;
    end
    if (beat) begin
      data_q[refill_index][beat_q] <= mem_r.rdata;   // Error responses fill the line too
    end
    if (last_beat) begin
      tag_q[refill_index] <= refill_tag;
    end
  end

endmodule

// ==== hw/ifu.sv ====
`timescale 1ns/1ns

module ifu (
  input  logic             clock,
  input  logic             reset,
  input  logic             jump_flush,
  input  fetch_pkg::addr_t jump_dnpc,
  input  logic             cs_flush,
  input  fetch_pkg::addr_t cs_dnpc,
  input  logic             out_ready,
  output logic             out_valid,
  output fetch_pkg::addr_t out_pc,
  output fetch_pkg::inst_t out_inst,
  output fetch_pkg::addr_t fetch_pc,
  input  logic             hit,
  input  fetch_pkg::inst_t cache_inst
);

  import fetch_pkg::*;

  typedef enum logic {
    st_wait,
    st_hold
  } state_t;

  state_t state, state_next;

  logic  out_valid_q, out_valid_next;
  addr_t fetch_pc_next;
  logic  pending_q, pending_next;
  addr_t pending_pc_q;
  logic  load_out;
  logic  store_pending;

  logic  redirect;
  addr_t redirect_pc;
  addr_t imm_b;
  logic  taken;
  addr_t predicted_pc;

  assign redirect    = jump_flush | cs_flush;
  assign redirect_pc = cs_flush ? cs_dnpc : jump_dnpc;   // CSR redirect wins

  // Static prediction: backward conditional branches are taken
  assign imm_b = {{20{cache_inst[31]}}, cache_inst[7], cache_inst[30:25],
                  cache_inst[11:8], 1'b0};
  assign taken = (cache_inst[6:2] == branch_opcode) && cache_inst[31];
  assign predicted_pc = fetch_pc + (taken ? imm_b : addr_t'(4));

  always_comb begin
    state_next     = state;
    out_valid_next = out_valid_q;
    fetch_pc_next  = fetch_pc;
    pending_next   = pending_q;
    load_out       = 1'b0;
    store_pending  = 1'b0;

    case (state)
      st_wait: begin
        if (hit) begin
          if (redirect || pending_q) begin
            pending_next   = 1'b0;
            out_valid_next = 1'b0;
            fetch_pc_next  = redirect ? redirect_pc : pending_pc_q;
          end else if (!out_valid_q || out_ready) begin
            out_valid_next = 1'b1;
            load_out       = 1'b1;
            fetch_pc_next  = predicted_pc;
          end else begin
            state_next = st_hold;                 // Output full, decode stalled
          end
        end else begin
          if (redirect) begin
            pending_next  = 1'b1;                 // Applied at the first hit
            store_pending = 1'b1;
          end
          if (out_ready || redirect) begin
            out_valid_next = 1'b0;
          end
        end
      end
      st_hold: begin
        if (redirect) begin
          state_next     = st_wait;
          out_valid_next = 1'b0;
          fetch_pc_next  = redirect_pc;
        end else if (out_ready) begin
          state_next = st_wait;
          if (hit) begin
            out_valid_next = 1'b1;
            load_out       = 1'b1;
            fetch_pc_next  = predicted_pc;
          end else begin
            out_valid_next = 1'b0;                // Line lost to fence.i while held
          end
        end
      end
      default: state_next = st_wait;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= st_wait;
      out_valid_q <= 1'b0;
      pending_q   <= 1'b0;
      fetch_pc    <= reset_pc;
    end else begin
      state       <= state_next;
      out_valid_q <= out_valid_next;
      pending_q   <= pending_next;
      fetch_pc    <= fetch_pc_next;
    end
  end

  always_ff @(posedge clock) begin
    if (load_out) begin
      out_pc   <= fetch_pc;
      out_inst <= cache_inst;
    end
    if (store_pending) begin
      pending_pc_q <= redirect_pc;
    end
  end

  assign out_valid = out_valid_q & ~redirect;   // Drop the instruction under a redirect

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top (
  input  logic               clock,
  input  logic               reset,
  input  logic               jump_flush,
  input  fetch_pkg::addr_t   jump_dnpc,
  input  logic               cs_flush,
  input  fetch_pkg::addr_t   cs_dnpc,
  input  logic               fencei,
  input  logic               out_ready,
  output logic               out_valid,
  output fetch_pkg::addr_t   out_pc,
  output fetch_pkg::inst_t   out_inst,
  output fetch_pkg::axi_ar_t mem_ar,
  input  fetch_pkg::axi_r_t  mem_r
);

  import fetch_pkg::*;

  addr_t fetch_pc;
  logic  hit;
  inst_t cache_inst;

  ifu u_ifu (
    .clock      (clock),
    .reset      (reset),
    .jump_flush (jump_flush),
    .jump_dnpc  (jump_dnpc),
    .cs_flush   (cs_flush),
    .cs_dnpc    (cs_dnpc),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_pc     (out_pc),
    .out_inst   (out_inst),
    .fetch_pc   (fetch_pc),
    .hit        (hit),
    .cache_inst (cache_inst)
  );

  icache u_icache (
    .clock  (clock),
    .reset  (reset),
    .fencei (fencei),
    .addr   (fetch_pc),
    .hit    (hit),
    .inst   (cache_inst),
    .mem_ar (mem_ar),
    .mem_r  (mem_r)
  );

endmodule

// ==== tests/fetch_props.sv ====
`timescale 1ns/1ns

module fetch_props (
  input logic               clock,
  input logic               reset,
  input logic               jump_flush,
  input logic               cs_flush,
  input logic               out_valid,
  input logic               out_ready,
  input fetch_pkg::addr_t   out_pc,
  input fetch_pkg::inst_t   out_inst,
  input fetch_pkg::axi_ar_t mem_ar,
  input fetch_pkg::axi_r_t  mem_r
);

  import fetch_pkg::*;

  int unsigned failures = 0;

  quiet_after_reset: assert property (@(posedge clock)
    reset |=> !out_valid && !mem_ar.arvalid && !mem_ar.rready)
    else begin failures++; $error("Outputs active right after reset"); end

  strobe_masks_valid: assert property (@(posedge clock) disable iff (reset)
    (jump_flush || cs_flush) |-> !out_valid)
    else begin failures++; $error("out_valid high during a redirect strobe"); end

  // Stalled output holds until drained or flushed
  stall_holds_output: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> jump_flush || cs_flush ||
      (out_valid && $stable(out_pc) && $stable(out_inst)))
    else begin failures++; $error("Output changed while decode stalled"); end

  ar_held_until_ready: assert property (@(posedge clock) disable iff (reset)
    mem_ar.arvalid && !mem_r.arready |=> mem_ar.arvalid && $stable(mem_ar.araddr))
    else begin failures++; $error("Read address dropped or changed before arready"); end

  ar_line_burst: assert property (@(posedge clock) disable iff (reset)
    mem_ar.arvalid |-> mem_ar.araddr[offset_w+1:0] == '0 &&
      mem_ar.arlen == 8'(line_words - 1) && mem_ar.arsize == 3'd2 && mem_ar.arburst == 2'b01)
    else begin failures++; $error("Read request is not a line-aligned INCR burst"); end

endmodule

bind fetch_top fetch_props u_props (.*);

// ==== tests/tb_fetch.sv ====
`timescale 1ns/1ns

module tb_fetch;

  import fetch_pkg::*;

  localparam int clock_period        = 4;
  localparam int image_words         = 256;   // 1 KiB at reset_pc
  localparam int loop_end            = 63;    // Main loop spans exactly one cache
  localparam int planned_transfers   = 800;
  localparam int refill_worst_cycles = 32;
  localparam int timeout_ns = planned_transfers * refill_worst_cycles * clock_period + 2000;

  logic    clock = 1'b0;
  logic    reset = 1'b1;
  logic    jump_flush, cs_flush, fencei, out_ready, out_valid;
  addr_t   jump_dnpc, cs_dnpc, out_pc;
  inst_t   out_inst;
  axi_ar_t mem_ar;
  axi_r_t  mem_r;

  inst_t       image [image_words];
  int          branch_to [image_words];      // Planted branch target word, or -1
  logic [31:0] lcg_state = 32'd8499;
  addr_t       exp_pc, burst_addr;
  int          beat_cnt, errors, checks, transfers, loops, requests;
  int          second_pass_requests, fence_first_word;
  logic        fence_sent, in_burst;

  fetch_top u_dut (.*);

  always #(clock_period / 2) clock = ~clock;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int word_of(addr_t a);
    return int'((a - reset_pc) >> 2);
  endfunction

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    errors++;
    $display("MISMATCH %s expected %h actual %h", name, expected, actual);
  endtask

  task automatic report_failure(string what);
    errors++;
    $display("ERROR %s", what);
  endtask

  // B-type encoding, funct3 kept in the branch group
  task automatic plant_branch(int from, int to);
    logic [12:0] imm;
    logic [31:0] r;
    imm = 13'((to - from) * 4);
    r = next_random();
    image[from] = {imm[12], imm[10:5], r[24:15], 1'b1, r[13:12], imm[4:1], imm[11], 7'b1100011};
    branch_to[from] = to;
  endtask

  task automatic build_image();
    logic [31:0] r;
    for (int i = 0; i < image_words; i++) begin
      r = next_random();
      image[i] = {r[31:7], 7'b0010011};   // OP-IMM
      branch_to[i] = -1;
    end
    plant_branch(loop_end, 0);
    plant_branch(96, 80);
    plant_branch(127, 64);
    plant_branch(255, 128);
  endtask

  task automatic check_transfer();
    int w;
    int exp_w;
    w     = word_of(out_pc);
    exp_w = word_of(exp_pc);
    transfers++;
    checks++;
    assert (out_pc == exp_pc) else report_mismatch("out_pc", exp_pc, out_pc);
    exp_pc = exp_pc + 4;
    if (exp_w < image_words && branch_to[exp_w] >= 0) begin
      exp_pc = reset_pc + addr_t'(4 * branch_to[exp_w]);
    end
    if (exp_w == loop_end) begin
      loops++;
    end
    if (w < image_words) begin
      checks++;
      assert (out_inst == image[w]) else report_mismatch("out_inst", image[w], out_inst);
    end else begin
      report_failure("transfer from outside the memory image");
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = next_random();
    out_ready  = r[31:30] != 2'b00;
    fencei     = 1'b0;
    jump_flush = 1'b0;
    cs_flush   = 1'b0;
    if (loops >= 2 && !fence_sent) begin
      fencei     = 1'b1;
      fence_sent = 1'b1;
    end else if (fence_sent) begin
      jump_flush = r[29:25] == '0;
      cs_flush   = r[24:20] == '0 || (jump_flush && r[19]);
      jump_dnpc  = reset_pc + ((next_random() >> 24) << 2);
      cs_dnpc    = reset_pc + ((next_random() >> 24) << 2);
    end
    mem_r.arready = !in_burst && r[15];
    mem_r.rvalid  = in_burst && r[14:13] != 2'b00;
    mem_r.rdata   = image[(word_of(burst_addr) + beat_cnt) % image_words];
    mem_r.rlast   = in_burst && beat_cnt == line_words - 1;
    mem_r.rresp   = 2'b00;
  endtask

  // Sampled mid-cycle, where DUT outputs and driven inputs are settled
  always @(negedge clock) begin
    if (!reset) begin
      if (jump_flush || cs_flush) begin
        checks++;
        assert (!out_valid) else report_failure("instruction offered during a redirect strobe");
      end
      if (out_valid && out_ready) begin
        check_transfer();
      end
      if (jump_flush || cs_flush) begin
        exp_pc = cs_flush ? cs_dnpc : jump_dnpc;
      end
      if (mem_ar.arvalid && mem_r.arready) begin
        requests++;
        checks++;
        assert (word_of(mem_ar.araddr) < image_words)
          else report_failure("read request outside the memory image");
        if (loops >= 1 && !fence_sent) begin
          second_pass_requests++;
        end
        if (fence_sent && fence_first_word < 0) begin
          fence_first_word = word_of(mem_ar.araddr);
        end
        burst_addr = mem_ar.araddr;
        beat_cnt   = 0;
        in_burst   = 1'b1;
      end
      if (mem_r.rvalid && mem_ar.rready) begin
        in_burst = !mem_r.rlast;
        beat_cnt++;
      end
    end
  end

  initial begin
    jump_flush = 1'b0;
    cs_flush   = 1'b0;
    fencei     = 1'b0;
    out_ready  = 1'b0;
    jump_dnpc  = reset_pc;
    cs_dnpc    = reset_pc;
    mem_r      = '0;
    exp_pc     = reset_pc;
    burst_addr = reset_pc;
    {beat_cnt, errors, checks, transfers, loops, requests} = '0;
    second_pass_requests = 0;
    fence_first_word     = -1;
    fence_sent = 1'b0;
    in_burst   = 1'b0;
    build_image();
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
    @(negedge clock);
    checks += 2;
    assert (!out_valid) else report_mismatch("out_valid", 0, out_valid);
    assert (!mem_ar.arvalid) else report_mismatch("arvalid", 0, mem_ar.arvalid);
    while (transfers < planned_transfers) begin
      @(posedge clock);
      #1 drive_inputs();
    end
    checks += 2;
    assert (second_pass_requests == 0) else report_failure("refill requested on the second pass");
    assert (fence_first_word >= 0 && fence_first_word <= loop_end)
      else report_failure("loop lines were not refilled right after fence.i");
    $display("checks %0d errors %0d assertion failures %0d transfers %0d requests %0d",
             checks, errors, u_dut.u_props.failures, transfers, requests);
    if (errors == 0 && u_dut.u_props.failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns with %0d of %0d transfers done",
             timeout_ns, transfers, planned_transfers);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== sim.f ====
hw/fetch_pkg.sv
hw/icache.sv
hw/ifu.sv
hw/fetch_top.sv
tests/fetch_props.sv
tests/tb_fetch.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/icache.sv
      - hw/ifu.sv
      - hw/fetch_top.sv
  - target: test
    files:
      - tests/fetch_props.sv
      - tests/tb_fetch.sv
